/* include/fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// datapath widths
`define FPU_DATA_W 64
`define FPU_LANE_W 32
`define FPU_TAG_W 6

// exception flags, bit 0 invalid, bit 1 denormal operand
`define FPU_FLAG_W 2
`define FPU_FLAG_INV 0
`define FPU_FLAG_DEN 1

// control word, trap enables ordered like the flags
`define FPU_CSR_W 32
`define FPU_CSR_EN_LSB 11

// double format fields
`define FPU_EXP_W 11
`define FPU_MAN_W 52

`endif

/* rtl/fpu_pkg.sv */
`default_nettype none

`include "fpu_defines.svh"

package fpu_pkg;

  typedef enum logic [2:0] {
    op_and,
    op_or,
    op_xor,
    op_andn,
    op_cmp_eq,
    op_cmp_lt,
    op_cmp_le,
    op_cmp_unord
  } p1_op_e;

  typedef enum logic [1:0] {
    op_swap,
    op_dupl,
    op_merge,
    op_copyb
  } p2_op_e;

  // operand source
  typedef enum logic [2:0] {
    fwd_reg,
    fwd_res1,
    fwd_res2,
    fwd_res1_old,
    fwd_res2_old
  } fwd_sel_e;

  typedef struct packed {
    p1_op_e                 op;
    logic                   ordered;
    logic [`FPU_TAG_W-1:0]  tag;
    logic [`FPU_DATA_W-1:0] a;
    logic [`FPU_DATA_W-1:0] b;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
  } p1_issue_t;

  typedef struct packed {
    p2_op_e                 op;
    logic [`FPU_TAG_W-1:0]  tag;
    logic [`FPU_DATA_W-1:0] a;
    logic [`FPU_DATA_W-1:0] b;
    fwd_sel_e               fwd_a;
    fwd_sel_e               fwd_b;
  } p2_issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`FPU_DATA_W-1:0] data;
  } result_t;

  typedef struct packed {
    logic eq;
    logic lt;
    logic gt;
    logic unord;
  } cmp_flags_t;

  typedef struct packed {
    logic [`FPU_TAG_W-1:0]  tag;
    logic [`FPU_FLAG_W-1:0] flags;
    logic                   trap;
  } retire_t;

endpackage

`default_nettype wire

/* rtl/operand_forward.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module operand_forward
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  fwd_sel_e               sel,
  input  logic [`FPU_DATA_W-1:0] reg_val,
  input  result_t                res1,
  input  result_t                res2,
  output logic [`FPU_DATA_W-1:0] operand
);

  fwd_sel_e               sel_q;
  logic [`FPU_DATA_W-1:0] reg_q;
  logic [`FPU_DATA_W-1:0] res1_old;
  logic [`FPU_DATA_W-1:0] res2_old;

  // select and register value captured at issue
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= fwd_reg;
    end else begin
      sel_q <= sel;
    end
    reg_q <= reg_val;
  end

  // previous-cycle bus copies
  always_ff @(posedge clk) begin
    if (rst) begin
      res1_old <= '0;
      res2_old <= '0;
    end else begin
      res1_old <= res1.data;
      res2_old <= res2.data;
    end
  end

  // bus data is taken whether or not its valid is set
  always_comb begin
    case (sel_q)
      fwd_res1:     operand = res1.data;
      fwd_res2:     operand = res2.data;
      fwd_res1_old: operand = res1_old;
      fwd_res2_old: operand = res2_old;
      default:      operand = reg_q;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/fp_cmp_logic.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module fp_cmp_logic
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  p1_op_e                 op,
  input  logic                   ordered,
  input  logic [`FPU_DATA_W-1:0] a,
  input  logic [`FPU_DATA_W-1:0] b,
  output logic [`FPU_DATA_W-1:0] data,
  output cmp_flags_t             flags,
  output logic [`FPU_FLAG_W-1:0] raised
);

  logic [`FPU_DATA_W-1:0]           a_q;
  logic [`FPU_DATA_W-1:0]           b_q;
  logic                             sign_a;
  logic                             sign_b;
  logic [`FPU_EXP_W-1:0]            exp_a;
  logic [`FPU_EXP_W-1:0]            exp_b;
  logic [`FPU_MAN_W-1:0]            man_a;
  logic [`FPU_MAN_W-1:0]            man_b;
  logic                             nan_a;
  logic                             nan_b;
  logic                             snan_a;
  logic                             snan_b;
  logic                             zero_a;
  logic                             zero_b;
  logic                             den_a;
  logic                             den_b;
  logic                             mag_lt;
  logic                             is_cmp;
  logic                             pred;
  cmp_flags_t                       cmp_c;
  logic [`FPU_FLAG_W-1:0]           raise_c;
  logic [`FPU_DATA_W-1:0]           res_c;

  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  assign {sign_a, exp_a, man_a} = a_q;
  assign {sign_b, exp_b, man_b} = b_q;

  assign nan_a  = (&exp_a) && (|man_a);
  assign nan_b  = (&exp_b) && (|man_b);
  // quiet bit is the mantissa msb
  assign snan_a = nan_a && !man_a[`FPU_MAN_W-1];
  assign snan_b = nan_b && !man_b[`FPU_MAN_W-1];
  assign zero_a = !(|exp_a) && !(|man_a);
  assign zero_b = !(|exp_b) && !(|man_b);
  assign den_a  = !(|exp_a) && (|man_a);
  assign den_b  = !(|exp_b) && (|man_b);

  // sign-magnitude order, magnitude sense flips for negatives
  assign mag_lt = (sign_a != sign_b) ? sign_a :
                  sign_a ? ({exp_a, man_a} > {exp_b, man_b}) :
                           ({exp_a, man_a} < {exp_b, man_b});

  always_comb begin
    cmp_c.unord = nan_a || nan_b;
    cmp_c.eq    = !cmp_c.unord && ((a_q == b_q) || (zero_a && zero_b));
    cmp_c.lt    = !cmp_c.unord && !cmp_c.eq && mag_lt;
    cmp_c.gt    = !cmp_c.unord && !cmp_c.eq && !mag_lt;

    raise_c = '0;
    raise_c[`FPU_FLAG_INV] = snan_a || snan_b || (ordered && cmp_c.unord);
    raise_c[`FPU_FLAG_DEN] = den_a || den_b;

    is_cmp = 1'b1;
    pred   = 1'b0;
    res_c  = '0;
    case (op)
      op_and:       begin is_cmp = 1'b0; res_c = a_q & b_q; end
      op_or:        begin is_cmp = 1'b0; res_c = a_q | b_q; end
      op_xor:       begin is_cmp = 1'b0; res_c = a_q ^ b_q; end
      // a and not b
      op_andn:      begin is_cmp = 1'b0; res_c = a_q & ~b_q; end
      op_cmp_eq:    pred = cmp_c.eq;
      op_cmp_lt:    pred = cmp_c.lt;
      op_cmp_le:    pred = cmp_c.lt || cmp_c.eq;
      default:      pred = cmp_c.unord;
    endcase
    if (is_cmp) begin
      res_c = {`FPU_DATA_W{pred}};
    end
  end

  always_ff @(posedge clk) begin
    data   <= res_c;
    raised <= is_cmp ? raise_c : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (is_cmp) begin
      flags <= cmp_c;
    end
  end

endmodule

`default_nettype wire

/* rtl/lane_permute.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module lane_permute
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  p2_op_e                 op,
  input  logic [`FPU_DATA_W-1:0] a,
  input  logic [`FPU_DATA_W-1:0] b,
  output logic [`FPU_DATA_W-1:0] data
);

  logic [`FPU_DATA_W-1:0] a_q;
  logic [`FPU_DATA_W-1:0] b_q;
  logic [`FPU_LANE_W-1:0] a_hi;
  logic [`FPU_LANE_W-1:0] a_lo;
  logic [`FPU_LANE_W-1:0] b_lo;
  logic [`FPU_DATA_W-1:0] res_c;

  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  assign a_hi = a_q[`FPU_LANE_W +: `FPU_LANE_W];
  assign a_lo = a_q[0 +: `FPU_LANE_W];
  assign b_lo = b_q[0 +: `FPU_LANE_W];

  // high lane listed first
  always_comb begin
    case (op)
      op_swap:  res_c = {a_lo, a_hi};
      op_dupl:  res_c = {a_lo, a_lo};
      op_merge: res_c = {a_hi, b_lo};
      default:  res_c = b_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data <= '0;
    end else begin
      data <= res_c;
    end
  end

endmodule

`default_nettype wire

/* rtl/excpt_report.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module excpt_report
  import fpu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`FPU_CSR_W-1:0]  fpcsr,
  input  logic                   done,
  input  logic [`FPU_TAG_W-1:0]  tag,
  input  logic [`FPU_FLAG_W-1:0] raised,
  output logic                   retire_en,
  output retire_t                retire
);

  logic [`FPU_FLAG_W-1:0] trap_en;

  // enable bits line up with the flag vector
  assign trap_en = fpcsr[`FPU_CSR_EN_LSB +: `FPU_FLAG_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_en <= 1'b0;
    end else begin
      retire_en <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      retire.tag   <= tag;
      retire.flags <= raised;
      retire.trap  <= |(raised & trap_en);
    end
  end

endmodule

`default_nettype wire

/* rtl/fpu_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_ctrl
  import fpu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  p1_issue_en,
  input  logic                  p2_issue_en,
  input  p1_op_e                p1_op,
  input  logic                  p1_ordered,
  input  logic [`FPU_TAG_W-1:0] p1_tag,
  input  p2_op_e                p2_op,
  output p1_op_e                p1_op_q,
  output logic                  p1_ordered_q,
  output p2_op_e                p2_op_q,
  output logic                  p1_done,
  output logic                  res1_valid,
  output logic                  res2_valid,
  output logic [`FPU_TAG_W-1:0] p1_done_tag
);

  logic                  p1_v1;
  logic                  p1_v2;
  logic                  p1_v3;
  logic                  p2_v1;
  logic                  p2_v2;
  logic                  p2_v3;
  p1_op_e                p1_op_s1;
  p2_op_e                p2_op_s1;
  logic                  p1_ord_s1;
  logic [`FPU_TAG_W-1:0] p1_tag_s1;
  logic [`FPU_TAG_W-1:0] p1_tag_s2;

  // valid pipes, issue edge then two stages
  always_ff @(posedge clk) begin
    if (rst) begin
      p1_v1 <= 1'b0;
      p1_v2 <= 1'b0;
      p1_v3 <= 1'b0;
      p2_v1 <= 1'b0;
      p2_v2 <= 1'b0;
      p2_v3 <= 1'b0;
    end else begin
      p1_v1 <= p1_issue_en;
      p1_v2 <= p1_v1;
      p1_v3 <= p1_v2;
      p2_v1 <= p2_issue_en;
      p2_v2 <= p2_v1;
      p2_v3 <= p2_v2;
    end
  end

  // opcodes for the stage 2 units
  // idle slots get a logic op so the compare flags hold
  always_ff @(posedge clk) begin
    if (rst) begin
      p1_op_s1 <= op_and;
      p1_op_q  <= op_and;
      p2_op_s1 <= op_swap;
      p2_op_q  <= op_swap;
    end else begin
      if (p1_issue_en) begin
        p1_op_s1 <= p1_op;
      end
      if (p2_issue_en) begin
        p2_op_s1 <= p2_op;
      end
      p1_op_q <= p1_v1 ? p1_op_s1 : op_and;
      p2_op_q <= p2_op_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (p1_issue_en) begin
      p1_ord_s1 <= p1_ordered;
      p1_tag_s1 <= p1_tag;
    end
    p1_ordered_q <= p1_ord_s1;
    p1_tag_s2    <= p1_tag_s1;
    p1_done_tag  <= p1_tag_s2;
  end

  assign res1_valid = p1_v3;
  assign res2_valid = p2_v3;
  // retire report is taken one edge after the result
  assign p1_done    = p1_v3;

endmodule

`default_nettype wire

/* rtl/fpu_cluster.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_cluster
  import fpu_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FPU_CSR_W-1:0] fpcsr,
  input  logic                  p1_issue_en,
  input  p1_issue_t             p1_issue,
  input  logic                  p2_issue_en,
  input  p2_issue_t             p2_issue,
  output result_t               res1,
  output result_t               res2,
  output cmp_flags_t            cmp_flags,
  output logic                  retire_en,
  output retire_t               retire
);

  p1_op_e                  p1_op_q;
  p2_op_e                  p2_op_q;
  logic                    p1_ordered_q;
  logic                    p1_done;
  logic                    res1_valid;
  logic                    res2_valid;
  logic [`FPU_TAG_W-1:0]   p1_done_tag;
  logic [`FPU_DATA_W-1:0]  p1_a;
  logic [`FPU_DATA_W-1:0]  p1_b;
  logic [`FPU_DATA_W-1:0]  p2_a;
  logic [`FPU_DATA_W-1:0]  p2_b;
  logic [`FPU_DATA_W-1:0]  p1_data;
  logic [`FPU_DATA_W-1:0]  p2_data;
  logic [`FPU_FLAG_W-1:0]  p1_raised;

  fpu_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .p1_issue_en  (p1_issue_en),
    .p2_issue_en  (p2_issue_en),
    .p1_op        (p1_issue.op),
    .p1_ordered   (p1_issue.ordered),
    .p1_tag       (p1_issue.tag),
    .p2_op        (p2_issue.op),
    .p1_op_q      (p1_op_q),
    .p1_ordered_q (p1_ordered_q),
    .p2_op_q      (p2_op_q),
    .p1_done      (p1_done),
    .res1_valid   (res1_valid),
    .res2_valid   (res2_valid),
    .p1_done_tag  (p1_done_tag)
  );

  // one forwarding mux per operand
  operand_forward u_fwd_p1_a (
    .clk(clk), .rst(rst), .sel(p1_issue.fwd_a), .reg_val(p1_issue.a),
    .res1(res1), .res2(res2), .operand(p1_a)
  );

  operand_forward u_fwd_p1_b (
    .clk(clk), .rst(rst), .sel(p1_issue.fwd_b), .reg_val(p1_issue.b),
    .res1(res1), .res2(res2), .operand(p1_b)
  );

  operand_forward u_fwd_p2_a (
    .clk(clk), .rst(rst), .sel(p2_issue.fwd_a), .reg_val(p2_issue.a),
    .res1(res1), .res2(res2), .operand(p2_a)
  );

  operand_forward u_fwd_p2_b (
    .clk(clk), .rst(rst), .sel(p2_issue.fwd_b), .reg_val(p2_issue.b),
    .res1(res1), .res2(res2), .operand(p2_b)
  );

  fp_cmp_logic u_cmp_logic (
    .clk     (clk),
    .rst     (rst),
    .op      (p1_op_q),
    .ordered (p1_ordered_q),
    .a       (p1_a),
    .b       (p1_b),
    .data    (p1_data),
    .flags   (cmp_flags),
    .raised  (p1_raised)
  );

  lane_permute u_permute (
    .clk  (clk),
    .rst  (rst),
    .op   (p2_op_q),
    .a    (p2_a),
    .b    (p2_b),
    .data (p2_data)
  );

  excpt_report u_excpt (
    .clk       (clk),
    .rst       (rst),
    .fpcsr     (fpcsr),
    .done      (p1_done),
    .tag       (p1_done_tag),
    .raised    (p1_raised),
    .retire_en (retire_en),
    .retire    (retire)
  );

  assign res1.valid = res1_valid;
  assign res1.data  = p1_data;
  assign res2.valid = res2_valid;
  assign res2.data  = p2_data;

endmodule

`default_nettype wire

/* bench/fpu_cluster_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module fpu_cluster_assert
  import fpu_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input logic    p1_issue_en,
  input logic    p2_issue_en,
  input result_t res1,
  input result_t res2,
  input logic    retire_en
);

  // issue sampled at edge E, valid high after E+2, seen at E+3
  a_res1_latency: assert property (@(posedge clk) disable iff (rst)
    p1_issue_en |-> ##3 res1.valid)
    else $error("res1.valid did not follow a port 1 issue by 2 cycles");

  a_res2_latency: assert property (@(posedge clk) disable iff (rst)
    p2_issue_en |-> ##3 res2.valid)
    else $error("res2.valid did not follow a port 2 issue by 2 cycles");

  a_retire_latency: assert property (@(posedge clk) disable iff (rst)
    p1_issue_en |-> ##4 retire_en)
    else $error("retire_en did not follow a port 1 issue by 3 cycles");

  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!res1.valid && !res2.valid && !retire_en))
    else $error("valid output high during reset");

endmodule

bind fpu_cluster fpu_cluster_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .p1_issue_en (p1_issue_en),
  .p2_issue_en (p2_issue_en),
  .res1        (res1),
  .res2        (res2),
  .retire_en   (retire_en)
);

`default_nettype wire

/* bench/fpu_cluster_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "fpu_defines.svh"

module fpu_cluster_tb
  import fpu_pkg::*;
;

  logic                  clk;
  logic                  rst;
  logic [`FPU_CSR_W-1:0] fpcsr;
  logic                  p1_issue_en;
  logic                  p2_issue_en;
  p1_issue_t             p1_issue;
  p2_issue_t             p2_issue;
  result_t               res1;
  result_t               res2;
  cmp_flags_t            cmp_flags;
  logic                  retire_en;
  retire_t               retire;

  // outstanding expectations, one entry per issue
  string       exp1_name_q[$];
  logic [63:0] exp1_data_q[$];
  logic [3:0]  exp1_flags_q[$];
  bit          exp1_cmp_q[$];
  string       exp2_name_q[$];
  logic [63:0] exp2_data_q[$];
  string       ret_name_q[$];
  logic [5:0]  ret_tag_q[$];
  logic [1:0]  ret_raised_q[$];
  logic        ret_trap_q[$];

  int          checks;
  int          errors;
  bit          aborted;
  logic [31:0] lfsr;
  logic [3:0]  held_flags;
  bit          flags_known;

  fpu_cluster DUT (
    .clk         (clk),
    .rst         (rst),
    .fpcsr       (fpcsr),
    .p1_issue_en (p1_issue_en),
    .p1_issue    (p1_issue),
    .p2_issue_en (p2_issue_en),
    .p2_issue    (p2_issue),
    .res1        (res1),
    .res2        (res2),
    .cmp_flags   (cmp_flags),
    .retire_en   (retire_en),
    .retire      (retire)
  );

  always #4 clk = ~clk;

  // galois lfsr, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [63:0] logic_model(input logic [1:0] op, input logic [63:0] a,
                                              input logic [63:0] b);
    case (op)
      2'd0:    return a & b;
      2'd1:    return a | b;
      2'd2:    return a ^ b;
      default: return a & ~b;
    endcase
  endfunction

  // lanes are 32 bits, high lane first
  function automatic logic [63:0] permute_model(input logic [1:0] op, input logic [63:0] a,
                                                input logic [63:0] b);
    case (op)
      2'd0:    return {a[31:0], a[63:32]};
      2'd1:    return {a[31:0], a[31:0]};
      2'd2:    return {a[63:32], b[31:0]};
      default: return b;
    endcase
  endfunction

  task automatic drive_p1(input string name, input logic [2:0] op, input logic ord,
                          input logic [5:0] tag, input logic [63:0] a, input logic [63:0] b,
                          input logic [2:0] fa, input logic [2:0] fb, input logic [63:0] exp,
                          input logic [3:0] flags, input bit is_cmp, input logic [1:0] raised,
                          input logic trap);
    p1_issue_en      = 1'b1;
    p1_issue.op      = p1_op_e'(op);
    p1_issue.ordered = ord;
    p1_issue.tag     = tag;
    p1_issue.a       = a;
    p1_issue.b       = b;
    p1_issue.fwd_a   = fwd_sel_e'(fa);
    p1_issue.fwd_b   = fwd_sel_e'(fb);
    // logic ops leave the last compare flags in place
    if (is_cmp) begin
      held_flags  = flags;
      flags_known = 1'b1;
    end
    exp1_name_q.push_back(name);
    exp1_data_q.push_back(exp);
    exp1_flags_q.push_back(held_flags);
    exp1_cmp_q.push_back(flags_known);
    ret_name_q.push_back(name);
    ret_tag_q.push_back(tag);
    ret_raised_q.push_back(raised);
    ret_trap_q.push_back(trap);
  endtask

  task automatic drive_p2(input string name, input logic [1:0] op, input logic [63:0] a,
                          input logic [63:0] b, input logic [2:0] fa, input logic [2:0] fb,
                          input logic [63:0] exp);
    p2_issue_en    = 1'b1;
    p2_issue.op    = p2_op_e'(op);
    p2_issue.tag   = '0;
    p2_issue.a     = a;
    p2_issue.b     = b;
    p2_issue.fwd_a = fwd_sel_e'(fa);
    p2_issue.fwd_b = fwd_sel_e'(fb);
    exp2_name_q.push_back(name);
    exp2_data_q.push_back(exp);
  endtask

  task automatic idle_issue();
    p1_issue_en = 1'b0;
    p2_issue_en = 1'b0;
    p1_issue    = '0;
    p2_issue    = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp1_data_q.size() != 0 || exp2_data_q.size() != 0 || ret_tag_q.size() != 0)
           && n < limit) begin
      next_cycle();
      n++;
    end
    if (exp1_data_q.size() != 0 || exp2_data_q.size() != 0 || ret_tag_q.size() != 0) begin
      $display("timeout: results still outstanding after %0d cycles", limit);
      aborted = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  always @(posedge clk) begin
    if (!rst && res1.valid) begin
      if (exp1_data_q.size() == 0) begin
        $display("port 1 gave a result with no issue outstanding");
        errors++;
      end else begin
        checks++;
        if (res1.data !== exp1_data_q[0]) begin
          $display("[FAIL] %s res1.data expected %h actual %h", exp1_name_q[0],
                   exp1_data_q[0], res1.data);
          errors++;
        end
        if (exp1_cmp_q[0]) begin
          checks++;
          if (cmp_flags !== exp1_flags_q[0]) begin
            $display("[FAIL] %s cmp_flags expected %h actual %h", exp1_name_q[0],
                     exp1_flags_q[0], cmp_flags);
            errors++;
          end
        end
        void'(exp1_name_q.pop_front());
        void'(exp1_data_q.pop_front());
        void'(exp1_flags_q.pop_front());
        void'(exp1_cmp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && res2.valid) begin
      if (exp2_data_q.size() == 0) begin
        $display("port 2 gave a result with no issue outstanding");
        errors++;
      end else begin
        checks++;
        if (res2.data !== exp2_data_q[0]) begin
          $display("[FAIL] %s res2.data expected %h actual %h", exp2_name_q[0],
                   exp2_data_q[0], res2.data);
          errors++;
        end
        void'(exp2_name_q.pop_front());
        void'(exp2_data_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && retire_en) begin
      if (ret_tag_q.size() == 0) begin
        $display("retire report with no port 1 issue outstanding");
        errors++;
      end else begin
        checks++;
        if (retire !== {ret_tag_q[0], ret_raised_q[0], ret_trap_q[0]}) begin
          $display("[FAIL] %s retire expected %h actual %h", ret_name_q[0],
                   {ret_tag_q[0], ret_raised_q[0], ret_trap_q[0]}, retire);
          errors++;
        end
        void'(ret_name_q.pop_front());
        void'(ret_tag_q.pop_front());
        void'(ret_raised_q.pop_front());
        void'(ret_trap_q.pop_front());
      end
    end
  end

  task automatic run_vectors();
    int          fd;
    int          r;
    int          port;
    int          errs_before;
    string       line;
    string       name;
    logic [2:0]  op;
    logic        ord;
    logic [5:0]  tag;
    logic [1:0]  en;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] data;
    logic [3:0]  flags;
    logic [1:0]  raised;
    logic        trap;
    fd = $fopen("bench/fpu_cluster_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      aborted = 1'b1;
      return;
    end
    while (!aborted && $fgets(line, fd) != 0) begin
      if (line.len() < 3 || line[0] == "#") begin
        continue;
      end
      r = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h", name, port, op, ord, tag,
                  en, a, b, data, flags, raised, trap);
      if (r != 12) begin
        $display("malformed vector line: %s", line);
        aborted = 1'b1;
        break;
      end
      errs_before = errors;
      next_cycle();
      fpcsr = {{(`FPU_CSR_W - 2){1'b0}}, en} << `FPU_CSR_EN_LSB;
      if (port == 1) begin
        drive_p1(name, op, ord, tag, a, b, 3'd0, 3'd0, data, flags, op[2], raised, trap);
      end else begin
        drive_p2(name, op[1:0], a, b, 3'd0, 3'd0, data);
      end
      next_cycle();
      idle_issue();
      wait_drain(20);
      report_test(name, errs_before);
    end
    $fclose(fd);
  endtask

  // current bus two cycles after issue, old copy three cycles after
  task automatic run_forwarding();
    logic [63:0] r[5];
    logic [63:0] x1;
    logic [63:0] x2;
    int          errs_before;
    errs_before = errors;
    for (int i = 0; i < 5; i++) begin
      r[i] = rand_bits(64);
    end
    x1 = logic_model(2'd2, r[0], r[1]);
    x2 = permute_model(2'd0, r[2], r[2]);
    next_cycle();
    drive_p1("fwd_src", 3'd2, 1'b0, 6'h20, r[0], r[1], 3'd0, 3'd0, x1, 4'h0, 1'b0, 2'd0, 1'b0);
    drive_p2("fwd_src", 2'd0, r[2], r[2], 3'd0, 3'd0, x2);
    next_cycle();
    idle_issue();
    next_cycle();
    drive_p1("fwd_cur", 3'd1, 1'b0, 6'h21, 64'h0, r[3], 3'd1, 3'd0,
             logic_model(2'd1, x1, r[3]), 4'h0, 1'b0, 2'd0, 1'b0);
    drive_p2("fwd_cur", 2'd2, 64'h0, r[4], 3'd2, 3'd0, permute_model(2'd2, x2, r[4]));
    next_cycle();
    drive_p1("fwd_old", 3'd0, 1'b0, 6'h22, 64'h0, 64'h0, 3'd3, 3'd4,
             logic_model(2'd0, x1, x2), 4'h0, 1'b0, 2'd0, 1'b0);
    drive_p2("fwd_old", 2'd3, 64'h0, 64'h0, 3'd0, 3'd3, x1);
    next_cycle();
    idle_issue();
    wait_drain(20);
    report_test("forwarding", errs_before);
  endtask

  task automatic run_throughput();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sel;
    int          errs_before;
    errs_before = errors;
    fpcsr = '1;
    for (int i = 0; i < 12; i++) begin
      next_cycle();
      a   = rand_bits(64);
      b   = rand_bits(64);
      sel = rand_bits(2);
      drive_p1("throughput", {1'b0, sel[1:0]}, 1'b0, 6'(i + 8'h30), a, b, 3'd0, 3'd0,
               logic_model(sel[1:0], a, b), 4'h0, 1'b0, 2'd0, 1'b0);
      a   = rand_bits(64);
      b   = rand_bits(64);
      sel = rand_bits(2);
      drive_p2("throughput", sel[1:0], a, b, 3'd0, 3'd0, permute_model(sel[1:0], a, b));
    end
    next_cycle();
    idle_issue();
    wait_drain(30);
    report_test("throughput", errs_before);
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    fpcsr       = '0;
    checks      = 0;
    errors      = 0;
    aborted     = 1'b0;
    lfsr        = 32'h4d48;
    held_flags  = '0;
    flags_known = 1'b0;
    idle_issue();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    run_vectors();
    if (!aborted) begin
      run_forwarding();
    end
    if (!aborted) begin
      run_throughput();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/fpu_cluster_vectors.txt */
# name port op ordered tag trap_en a b exp_data exp_flags(eq,lt,gt,unord) exp_raised exp_trap
# hex fields except port; port 1 ops 0..7 and..cmp_unord, port 2 ops 0..3 swap..copyb
and_bits 1 0 0 01 0 ff00ff0012345678 0f0f0f0fffff0000 0f000f0012340000 0 0 0
or_bits 1 1 0 02 0 f0f0000000000001 0f0f000000000002 ffff000000000003 0 0 0
xor_bits 1 2 0 03 0 aaaaaaaa55555555 ffffffff00000000 5555555555555555 0 0 0
andn_bits 1 3 0 04 0 ffffffffffffffff 00000000ffffffff ffffffff00000000 0 0 0
eq_one 1 4 0 05 0 3ff0000000000000 3ff0000000000000 ffffffffffffffff 8 0 0
lt_one_two 1 5 0 06 0 3ff0000000000000 4000000000000000 ffffffffffffffff 4 0 0
le_two_one 1 6 0 07 0 4000000000000000 3ff0000000000000 0000000000000000 2 0 0
lt_neg_pos 1 5 0 08 0 bff0000000000000 3ff0000000000000 ffffffffffffffff 4 0 0
lt_neg_neg 1 5 0 09 0 c000000000000000 bff0000000000000 ffffffffffffffff 4 0 0
eq_zeros 1 4 0 0a 0 0000000000000000 8000000000000000 ffffffffffffffff 8 0 0
lt_denorm 1 5 0 0b 0 0000000000000001 3ff0000000000000 ffffffffffffffff 4 2 0
eq_qnan 1 4 0 0c 0 7ff8000000000000 3ff0000000000000 0000000000000000 1 0 0
unord_qnan_ord 1 7 1 0d 0 7ff8000000000000 3ff0000000000000 ffffffffffffffff 1 1 0
unord_snan_trap 1 7 0 0e 1 7ff0000000000001 3ff0000000000000 ffffffffffffffff 1 1 1
le_denorm_trap 1 6 0 0f 2 0000000000000001 0000000000000001 ffffffffffffffff 8 2 1
eq_snan_notrap 1 4 0 10 2 7ff0000000000001 3ff0000000000000 0000000000000000 1 1 0
swap 2 0 0 00 0 1111111122222222 0000000000000000 2222222211111111 0 0 0
dupl 2 1 0 00 0 aaaaaaaabbbbbbbb 0000000000000000 bbbbbbbbbbbbbbbb 0 0 0
merge 2 2 0 00 0 1234567800000000 ffffffff9abcdef0 123456789abcdef0 0 0 0
copyb 2 3 0 00 0 0000000000000000 0123456789abcdef 0123456789abcdef 0 0 0

/* fpu_cluster.f */
+incdir+include
rtl/fpu_pkg.sv
rtl/operand_forward.sv
rtl/fp_cmp_logic.sv
rtl/lane_permute.sv
rtl/excpt_report.sv
rtl/fpu_ctrl.sv
rtl/fpu_cluster.sv
bench/fpu_cluster_assert.sv
bench/fpu_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fpu_cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f fpu_cluster.f \
  --top-module fpu_cluster_tb -o fpu_cluster_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

./obj_dir/fpu_cluster_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
